//--- logic/tcb_lite_pkg.sv
package tcb_lite_pkg;

    ////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////

    // byte address width
    localparam int unsigned adr_w = 16;
    // data width
    localparam int unsigned dat_w = 32;
    // one enable per data byte
    localparam int unsigned ben_w = dat_w / 8;

    // fixed response delay, transfer edge to response
    localparam int unsigned dly = 1;

    // memory size in words
    // word index from adr[9:2], anything at 1024 or above is out of range
    localparam int unsigned mem_depth = 256;

    ////////////////////////////////////////////////////////////
    // request and response payloads
    ////////////////////////////////////////////////////////////

    // request, 53 bits
    typedef struct packed {
        logic             wen;  // 1 for write
        logic [adr_w-1:0] adr;  // byte address
        logic [ben_w-1:0] ben;  // byte enables
        logic [dat_w-1:0] wdt;  // write data
    } req_t;

    // response, 33 bits
    typedef struct packed {
        logic [dat_w-1:0] rdt;  // read data
        logic             err;  // out of range access
    } rsp_t;

endpackage: tcb_lite_pkg

//--- logic/tcb_lite_arb_pkg.sv
package tcb_lite_arb_pkg;

    ////////////////////////////////////////////////////////////
    // interconnect size
    ////////////////////////////////////////////////////////////

    // number of managers
    localparam int unsigned ifn = 3;
    // select index width
    localparam int unsigned ifl = $clog2(ifn);

    // select index
    typedef logic [ifl-1:0] sel_t;

    ////////////////////////////////////////////////////////////
    // priority table
    ////////////////////////////////////////////////////////////

    // entry r holds the manager of rank r
    // rank 0 wins, so manager 1 first, then 0, then 2
    localparam sel_t pri [0:ifn-1] = '{
        sel_t'(1),
        sel_t'(0),
        sel_t'(2)
    };

endpackage: tcb_lite_arb_pkg

//--- logic/tcb_lite_lib_arbiter.sv
`timescale 1ns/1ps

module tcb_lite_lib_arbiter (
    // manager valids
    input  logic [tcb_lite_arb_pkg::ifn-1:0] vld,
    // winning manager
    output tcb_lite_arb_pkg::sel_t           sel
);

    ////////////////////////////////////////////////////////////
    // helper functions
    ////////////////////////////////////////////////////////////

    // valids sorted by rank
    // bit r is the valid of manager pri[r]
    function automatic logic [tcb_lite_arb_pkg::ifn-1:0] reorder (
        input logic [tcb_lite_arb_pkg::ifn-1:0] val
    );
        logic [tcb_lite_arb_pkg::ifn-1:0] res;
        for (int unsigned r = 0; r < tcb_lite_arb_pkg::ifn; r++) begin
            res[r] = val[tcb_lite_arb_pkg::pri[r]];
        end
        return res;
    endfunction: reorder

    // lowest set rank
    function automatic tcb_lite_arb_pkg::sel_t encode (
        input logic [tcb_lite_arb_pkg::ifn-1:0] val
    );
        tcb_lite_arb_pkg::sel_t enc;
        // nothing valid, result is don't care
        enc = 'x;
        // scan down so the lowest rank is the last hit
        for (int r = tcb_lite_arb_pkg::ifn - 1; r >= 0; r--) begin
            if (val[r]) begin
                enc = tcb_lite_arb_pkg::sel_t'(r);
            end
        end
        return enc;
    endfunction: encode

    ////////////////////////////////////////////////////////////
    // fixed priority
    ////////////////////////////////////////////////////////////

    // ranked valids
    logic [tcb_lite_arb_pkg::ifn-1:0] rnk_vld;
    // winning rank
    tcb_lite_arb_pkg::sel_t           rnk;

    assign rnk_vld = reorder(vld);
    assign rnk     = encode(rnk_vld);

    // rank back to manager index
    assign sel = tcb_lite_arb_pkg::pri[rnk];

endmodule: tcb_lite_lib_arbiter

//--- logic/tcb_lite_lib_multiplexer.sv
`timescale 1ns/1ps

module tcb_lite_lib_multiplexer (
    input  logic                             clk,
    input  logic                             arst_n,
    // select from the arbiter
    input  tcb_lite_arb_pkg::sel_t           sel,
    // manager side
    input  logic [tcb_lite_arb_pkg::ifn-1:0] man_vld,
    input  tcb_lite_pkg::req_t               man_req [0:tcb_lite_arb_pkg::ifn-1],
    output logic [tcb_lite_arb_pkg::ifn-1:0] man_rdy,
    output tcb_lite_pkg::rsp_t               man_rsp [0:tcb_lite_arb_pkg::ifn-1],
    // subordinate side
    output logic                             sub_vld,
    output tcb_lite_pkg::req_t               sub_req,
    input  logic                             sub_rdy,
    input  tcb_lite_pkg::rsp_t               sub_rsp
);

    ////////////////////////////////////////////////////////////
    // request path
    ////////////////////////////////////////////////////////////

    // transfer on the subordinate side
    logic trn;

    // the arbiter always points at a valid manager
    // when there is one, so any valid means sub_vld
    assign sub_vld = |man_vld;

    // selected request
    assign sub_req = man_req[sel];

    // rdy only for the winner
    // also masked by vld, so idle managers see 0
    always_comb begin
        for (int unsigned i = 0; i < tcb_lite_arb_pkg::ifn; i++) begin
            man_rdy[i] = sub_rdy & man_vld[i] & (sel == tcb_lite_arb_pkg::sel_t'(i));
        end
    end

    assign trn = sub_vld & sub_rdy;

    ////////////////////////////////////////////////////////////
    // select pipeline
    ////////////////////////////////////////////////////////////

    // owner of each transfer still in flight
    // last stage owns the response on sub_rsp
    tcb_lite_arb_pkg::sel_t sel_dly [0:tcb_lite_pkg::dly-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int unsigned s = 0; s < tcb_lite_pkg::dly; s++) begin
                sel_dly[s] <= '0;
            end
        end else begin
            // first stage only loads on a transfer
            // idle slots carry a zero response anyway
            if (trn) begin
                sel_dly[0] <= sel;
            end
            // shift toward the response end
            for (int unsigned s = 1; s < tcb_lite_pkg::dly; s++) begin
                sel_dly[s] <= sel_dly[s-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // response path
    ////////////////////////////////////////////////////////////

    // response owner
    tcb_lite_arb_pkg::sel_t rsp_sel;

    assign rsp_sel = sel_dly[tcb_lite_pkg::dly-1];

    // copy to the owner, zero elsewhere
    always_comb begin
        for (int unsigned i = 0; i < tcb_lite_arb_pkg::ifn; i++) begin
            if (rsp_sel == tcb_lite_arb_pkg::sel_t'(i)) begin
                man_rsp[i] = sub_rsp;
            end else begin
                man_rsp[i] = '0;
            end
        end
    end

endmodule: tcb_lite_lib_multiplexer

//--- logic/tcb_lite_mem.sv
`timescale 1ns/1ps

module tcb_lite_mem (
    input  logic               clk,
    input  logic               arst_n,
    // TCB subordinate port
    input  logic               vld,
    input  tcb_lite_pkg::req_t req,
    output logic               rdy,
    output tcb_lite_pkg::rsp_t rsp
);

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////

    // storage
    logic [tcb_lite_pkg::dat_w-1:0] mem [0:tcb_lite_pkg::mem_depth-1];

    // word index, byte offset bits dropped
    logic [$clog2(tcb_lite_pkg::mem_depth)-1:0] idx;
    // address past the end of the array
    logic                                       oor;

    assign idx = req.adr[$clog2(tcb_lite_pkg::mem_depth)+1:2];
    assign oor = req.adr >= tcb_lite_pkg::adr_w'(tcb_lite_pkg::mem_depth * tcb_lite_pkg::ben_w);

    // never stalls
    assign rdy = 1'b1;

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    // byte lanes under ben, out of range writes ignored
    always_ff @(posedge clk) begin
        if (vld && req.wen && !oor) begin
            for (int unsigned b = 0; b < tcb_lite_pkg::ben_w; b++) begin
                if (req.ben[b]) begin
                    mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // response register
    ////////////////////////////////////////////////////////////

    // one cycle after the transfer
    // zero when nothing was transferred
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp <= '0;
        end else if (vld) begin
            rsp.err <= oor;
            // writes and bad reads return 0
            if (!req.wen && !oor) begin
                rsp.rdt <= mem[idx];
            end else begin
                rsp.rdt <= '0;
            end
        end else begin
            rsp <= '0;
        end
    end

endmodule: tcb_lite_mem

//--- logic/tcb_lite_interconnect.sv
`timescale 1ns/1ps

module tcb_lite_interconnect (
    input  logic                             clk,
    input  logic                             arst_n,
    // manager ports
    input  logic [tcb_lite_arb_pkg::ifn-1:0] man_vld,
    input  tcb_lite_pkg::req_t               man_req [0:tcb_lite_arb_pkg::ifn-1],
    output logic [tcb_lite_arb_pkg::ifn-1:0] man_rdy,
    output tcb_lite_pkg::rsp_t               man_rsp [0:tcb_lite_arb_pkg::ifn-1]
);

    ////////////////////////////////////////////////////////////
    // local signals
    ////////////////////////////////////////////////////////////

    // arbiter choice
    tcb_lite_arb_pkg::sel_t sel;

    // subordinate side
    logic                   sub_vld;
    tcb_lite_pkg::req_t     sub_req;
    logic                   sub_rdy;
    tcb_lite_pkg::rsp_t     sub_rsp;

    ////////////////////////////////////////////////////////////
    // instances
    ////////////////////////////////////////////////////////////

    // fixed priority pick
    tcb_lite_lib_arbiter i_arb (
        .vld     (man_vld),
        .sel     (sel)
    );

    // request forward, response return
    tcb_lite_lib_multiplexer i_mux (
        .clk     (clk),
        .arst_n  (arst_n),
        .sel     (sel),
        .man_vld (man_vld),
        .man_req (man_req),
        .man_rdy (man_rdy),
        .man_rsp (man_rsp),
        .sub_vld (sub_vld),
        .sub_req (sub_req),
        .sub_rdy (sub_rdy),
        .sub_rsp (sub_rsp)
    );

    // shared memory
    tcb_lite_mem i_mem (
        .clk     (clk),
        .arst_n  (arst_n),
        .vld     (sub_vld),
        .req     (sub_req),
        .rdy     (sub_rdy),
        .rsp     (sub_rsp)
    );

endmodule: tcb_lite_interconnect

//--- sim/tcb_lite_interconnect_tb.sv
`timescale 1ns/1ps

module tcb_lite_interconnect_tb;

    ////////////////////////////////////////////////////////////
    // run length
    ////////////////////////////////////////////////////////////

    // response delay in cycles
    localparam int rsp_dly      = tcb_lite_pkg::dly;
    // random transfers in the last test
    localparam int n_rand       = 600;
    // one lone transfer needs 2 cycles plus 1 of margin
    localparam int cyc_per_xfer = 3;
    // directed tests stay well under 200 cycles
    // limit is about twice the whole run
    localparam int max_cycles   = 2 * (n_rand * cyc_per_xfer + 200);
    // longest wait for rdy in one transfer
    localparam int rdy_limit    = 16;
    // reads in the pipelined test
    localparam int n_pipe       = 6;

    // dut ports
    logic                             clk;
    logic                             arst_n;
    logic [tcb_lite_arb_pkg::ifn-1:0] man_vld;
    tcb_lite_pkg::req_t               man_req [0:tcb_lite_arb_pkg::ifn-1];
    logic [tcb_lite_arb_pkg::ifn-1:0] man_rdy;
    tcb_lite_pkg::rsp_t               man_rsp [0:tcb_lite_arb_pkg::ifn-1];

    // reference memory
    logic [31:0] ref_mem [0:255];
    // words holding known data
    bit          ref_set [0:255];

    // fibonacci lfsr
    logic [15:0] lfsr = 16'd15672;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    tcb_lite_interconnect i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .man_vld (man_vld),
        .man_req (man_req),
        .man_rdy (man_rdy),
        .man_rsp (man_rsp)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // watchdog
    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles because the tests did not finish", cycles);
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // taps 16 14 13 11
    function automatic logic next_lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    // one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_lfsr_bit()};
        end
        return v;
    endfunction

    // managers 0 to 2 with code 3 redrawn
    function automatic logic [1:0] pick_manager();
        logic [1:0] m;
        m = 2'(random_bits(2));
        while (m == 2'd3) begin
            m = 2'(random_bits(2));
        end
        return m;
    endfunction

    function automatic logic [2:0] onehot(input logic [1:0] m);
        return 3'b001 << m;
    endfunction

    function automatic tcb_lite_pkg::req_t make_req(
        input logic wen, input logic [15:0] adr, input logic [3:0] ben, input logic [31:0] wdt
    );
        tcb_lite_pkg::req_t req;
        req.wen = wen;
        req.adr = adr;
        req.ben = ben;
        req.wdt = wdt;
        return req;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // 1024 bytes mapped
    // word index from adr[9:2]
    function automatic tcb_lite_pkg::rsp_t predict_response(input tcb_lite_pkg::req_t req);
        tcb_lite_pkg::rsp_t rsp;
        rsp.err = (req.adr >= 16'd1024);
        if (!req.wen && !rsp.err) begin
            rsp.rdt = ref_mem[req.adr[9:2]];
        end else begin
            rsp.rdt = '0;
        end
        return rsp;
    endfunction

    // byte merge under ben
    function automatic void update_model(input tcb_lite_pkg::req_t req);
        logic [7:0] idx;
        idx = req.adr[9:2];
        if (req.wen && req.adr < 16'd1024) begin
            for (int b = 0; b < 4; b++) begin
                if (req.ben[b]) begin
                    ref_mem[idx][8*b +: 8] = req.wdt[8*b +: 8];
                end
            end
            ref_set[idx] = 1'b1;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // owner sees exp and everyone else 0
    // owner of -1 means no response due
    task automatic compare_responses(
        input string name, input int owner, input tcb_lite_pkg::rsp_t exp
    );
        for (int i = 0; i < tcb_lite_arb_pkg::ifn; i++) begin
            if (i == owner) begin
                check_value(name, 64'(exp), 64'(man_rsp[i]));
            end else begin
                check_value(name, 64'd0, 64'(man_rsp[i]));
            end
        end
    endtask

    // one manager alone
    // raise vld and wait for rdy
    // rsp checked dly cycles after the transfer
    task automatic do_transfer(
        input string name, input logic [1:0] m, input logic wen,
        input logic [15:0] adr, input logic [3:0] ben, input logic [31:0] wdt
    );
        tcb_lite_pkg::req_t req;
        tcb_lite_pkg::rsp_t exp;
        int                 waited;
        req    = make_req(wen, adr, ben, wdt);
        exp    = predict_response(req);
        waited = 0;
        @(posedge clk);
        man_vld[m] <= 1'b1;
        man_req[m] <= req;
        @(negedge clk);
        while (!man_rdy[m] && waited < rdy_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!man_rdy[m]) begin
            errors++;
            $display("manager %0d never saw rdy in test %s", m, name);
            @(posedge clk);
            man_vld[m] <= 1'b0;
        end else begin
            // transfer edge
            @(posedge clk);
            man_vld[m] <= 1'b0;
            update_model(req);
            repeat (rsp_dly - 1) @(posedge clk);
            @(negedge clk);
            compare_responses(name, int'(m), exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic single_manager_rw();
        logic [31:0] data;
        // quiet bus after reset
        @(negedge clk);
        check_value("idle rdy", 64'd0, 64'(man_rdy));
        compare_responses("idle rsp", -1, '0);
        for (int m = 0; m < 3; m++) begin
            data = random_bits(32);
            do_transfer("single write", 2'(m), 1'b1, 16'(16'h0010 + 4 * m), 4'hf, data);
            do_transfer("single read", 2'(m), 1'b0, 16'(16'h0010 + 4 * m), 4'hf, 32'd0);
        end
    endtask

    task automatic partial_write_merge();
        do_transfer("partial write", 2'd0, 1'b1, 16'h0040, 4'hf, random_bits(32));
        do_transfer("partial write", 2'd1, 1'b1, 16'h0040, 4'b0110, random_bits(32));
        do_transfer("partial write", 2'd2, 1'b1, 16'h0041, 4'b1000, random_bits(32));
        do_transfer("partial read", 2'd0, 1'b0, 16'h0040, 4'hf, 32'd0);
    endtask

    // all three valid in one cycle
    task automatic contention_order();
        logic [1:0]         order [0:2];
        tcb_lite_pkg::req_t req   [0:2];
        tcb_lite_pkg::rsp_t exp   [0:2];
        // winners in rank order
        order  = '{2'd1, 2'd0, 2'd2};
        req[0] = make_req(1'b0, 16'h0010, 4'hf, 32'd0);
        req[1] = make_req(1'b0, 16'h0014, 4'hf, 32'd0);
        req[2] = make_req(1'b0, 16'h0040, 4'hf, 32'd0);
        exp[0] = predict_response(req[0]);
        exp[1] = predict_response(req[1]);
        exp[2] = predict_response(req[2]);
        @(posedge clk);
        man_vld    <= 3'b111;
        man_req[0] <= req[0];
        man_req[1] <= req[1];
        man_req[2] <= req[2];
        for (int j = 0; j < 3 + rsp_dly; j++) begin
            @(negedge clk);
            if (j < 3) begin
                check_value("contention rdy", 64'(onehot(order[j])), 64'(man_rdy));
            end else begin
                check_value("contention rdy", 64'd0, 64'(man_rdy));
            end
            // waiting managers must see no response
            if (j >= rsp_dly) begin
                compare_responses("contention rsp", int'(order[j-rsp_dly]),
                                  exp[order[j-rsp_dly]]);
            end else begin
                compare_responses("contention rsp", -1, '0);
            end
            @(posedge clk);
            if (j < 3) begin
                man_vld <= man_vld & ~onehot(order[j]);
            end
        end
    endtask

    // one read per cycle from changing managers
    task automatic pipelined_reads();
        logic [1:0]         mgr [0:n_pipe-1];
        tcb_lite_pkg::req_t req [0:n_pipe-1];
        tcb_lite_pkg::rsp_t exp [0:n_pipe-1];
        mgr = '{2'd0, 2'd2, 2'd1, 2'd0, 2'd2, 2'd1};
        for (int k = 0; k < n_pipe; k++) begin
            do_transfer("pipelined fill", 2'd2, 1'b1, 16'(16'h0100 + 4 * k), 4'hf,
                        random_bits(32));
        end
        for (int k = 0; k < n_pipe; k++) begin
            req[k] = make_req(1'b0, 16'(16'h0100 + 4 * k), 4'hf, 32'd0);
            exp[k] = predict_response(req[k]);
        end
        @(posedge clk);
        man_vld         <= onehot(mgr[0]);
        man_req[mgr[0]] <= req[0];
        for (int j = 0; j < n_pipe + rsp_dly; j++) begin
            @(negedge clk);
            if (j < n_pipe) begin
                check_value("pipelined rdy", 64'(onehot(mgr[j])), 64'(man_rdy));
            end else begin
                check_value("pipelined rdy", 64'd0, 64'(man_rdy));
            end
            if (j >= rsp_dly) begin
                compare_responses("pipelined rsp", int'(mgr[j-rsp_dly]), exp[j-rsp_dly]);
            end else begin
                compare_responses("pipelined rsp", -1, '0);
            end
            @(posedge clk);
            if (j + 1 < n_pipe) begin
                man_vld           <= onehot(mgr[j+1]);
                man_req[mgr[j+1]] <= req[j+1];
            end else begin
                man_vld <= '0;
            end
        end
    endtask

    // 0x0420 aliases word 0x0020
    task automatic out_of_range_access();
        do_transfer("range write", 2'd0, 1'b1, 16'h0020, 4'hf, random_bits(32));
        do_transfer("range bad write", 2'd1, 1'b1, 16'h0420, 4'hf, random_bits(32));
        do_transfer("range bad read", 2'd2, 1'b0, 16'h0420, 4'hf, 32'd0);
        do_transfer("range bad read", 2'd1, 1'b0, 16'hfffc, 4'hf, 32'd0);
        do_transfer("range alias read", 2'd0, 1'b0, 16'h0020, 4'hf, 32'd0);
    endtask

    task automatic mixed_traffic();
        logic [1:0]  m;
        logic [7:0]  widx;
        logic        wen;
        logic [3:0]  ben;
        logic [15:0] adr;
        for (int n = 0; n < n_rand; n++) begin
            m    = pick_manager();
            widx = 8'(random_bits(8));
            adr  = {6'd0, widx, 2'(random_bits(2))};
            wen  = 1'(random_bits(1));
            ben  = 4'(random_bits(4));
            // unknown words get a full write first
            if (!ref_set[widx]) begin
                wen = 1'b1;
                ben = 4'hf;
            end
            do_transfer("random", m, wen, adr, ben, random_bits(32));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        arst_n  <= 1'b0;
        man_vld <= '0;
        man_req <= '{default: '0};
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        single_manager_rw();
        partial_write_merge();
        contention_order();
        pipelined_reads();
        out_of_range_access();
        mixed_traffic();
        @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule: tcb_lite_interconnect_tb

//--- tcb_lite_interconnect.f
logic/tcb_lite_pkg.sv
logic/tcb_lite_arb_pkg.sv
logic/tcb_lite_lib_arbiter.sv
logic/tcb_lite_lib_multiplexer.sv
logic/tcb_lite_mem.sv
logic/tcb_lite_interconnect.sv
sim/tcb_lite_interconnect_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the interconnect testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tcb_lite_interconnect_tb \
    -f tcb_lite_interconnect.f \
    -o tcb_lite_interconnect_sim

./obj_dir/tcb_lite_interconnect_sim > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failure"
